/* src/posit_pkg.sv */
package posit_pkg;

  // Width of the signed regime value k.
  // It covers k from -(N-1) up to N-2.
  function automatic int regime_bits_f(input int n);
    return $clog2(n) + 1;
  endfunction

  // The total exponent is k followed by the ES exponent bits.
  function automatic int te_bits_f(input int n, input int es);
    return regime_bits_f(n) + es;
  endfunction

  // Sign, the shortest regime (two bits) and ES exponent bits leave this many fraction bits.
  function automatic int mant_size_f(input int n, input int es);
    return n - 3 - es;
  endfunction

  // Long FIR fraction, wide enough for the full product of two mantissas.
  function automatic int frac_full_size_f(input int n, input int es);
    return 2 * mant_size_f(n, es) + 2;
  endfunction

endpackage

/* src/ppu_ops_pkg.sv */
package ppu_ops_pkg;

  localparam int OP_BITS = 2;

  // A sum or a product can need one more exponent bit than an operand.
  localparam int TE_GROW = 1;

  // Carry bit on top and sticky slot at the bottom of the adder.
  localparam int ALIGN_EXTRA_BITS = 2;

  // Code 2'b11 is reserved and is treated like OP_ADD.
  typedef enum logic [OP_BITS-1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10
  } op_e;

endpackage

/* src/posit_to_fir.sv */
module posit_to_fir
  import posit_pkg::*;
#(
  parameter int N = 16,
  parameter int ES = 1,
  localparam int RB = regime_bits_f(N),
  localparam int TE = te_bits_f(N, ES),
  localparam int M = mant_size_f(N, ES)
) (
  input  logic [N-1:0]          posit_i,
  output logic                  sign_o,
  output logic signed [TE-1:0]  te_o,
  output logic [M-1:0]          frac_o,
  output logic                  is_zero_o,
  output logic                  is_nar_o
);

  logic [N-1:0]          abs_posit;
  logic [N-2:0]          body;
  logic                  regime_polarity;
  logic [RB-1:0]         run_len;
  logic signed [RB-1:0]  k;
  logic [N-2:0]          after_regime;
  logic [ES-1:0]         exp_bits;

  assign sign_o          = posit_i[N-1];
  assign abs_posit       = sign_o ? -posit_i : posit_i;  // Fields are read from the magnitude.
  assign body            = abs_posit[N-2:0];
  assign regime_polarity = body[N-2];

  // Length of the leading run of identical regime bits.
  always_comb begin
    logic run_open;
    run_len  = '0;
    run_open = 1'b1;
    for (int i = N - 2; i >= 0; i--) begin
      if (run_open && (body[i] == regime_polarity)) begin
        run_len = run_len + 1'b1;
      end else begin
        run_open = 1'b0;
      end
    end
  end

  // A run of ones gives k = run - 1, a run of zeros gives k = -run.
  assign k = regime_polarity ? $signed(run_len - 1'b1) : -$signed(run_len);

  // Drop the run and its terminator so the exponent sits at the top.
  assign after_regime = body << (run_len + 1'b1);
  assign exp_bits     = after_regime[N-2 -: ES];
  assign frac_o       = after_regime[N-2-ES -: M];  // Left aligned, missing bits read as zero.

  // Since the exponent is never negative, k and exp concatenate into k * 2^ES + exp.
  assign te_o = {k, exp_bits};

  assign is_zero_o = (posit_i == '0);
  assign is_nar_o  = (posit_i == {1'b1, {(N-1){1'b0}}});

endmodule

/* src/posit_ops.sv */
module posit_ops
  import posit_pkg::*;
  import ppu_ops_pkg::*;
#(
  parameter int N = 16,
  parameter int ES = 1,
  localparam int TE = te_bits_f(N, ES),
  localparam int TEW = TE + TE_GROW,
  localparam int M = mant_size_f(N, ES),
  localparam int FF = frac_full_size_f(N, ES)
) (
  input  op_e                   op_i,
  input  logic                  a_sign_i,
  input  logic signed [TE-1:0]  a_te_i,
  input  logic [M-1:0]          a_frac_i,
  input  logic                  a_is_zero_i,
  input  logic                  a_is_nar_i,
  input  logic                  b_sign_i,
  input  logic signed [TE-1:0]  b_te_i,
  input  logic [M-1:0]          b_frac_i,
  input  logic                  b_is_zero_i,
  input  logic                  b_is_nar_i,
  output logic                  res_sign_o,
  output logic signed [TEW-1:0] res_te_o,
  output logic [FF-1:0]         res_frac_full_o,
  output logic                  frac_truncated_o,
  output logic                  res_is_zero_o,
  output logic                  res_is_nar_o
);

  localparam int AW = FF + ALIGN_EXTRA_BITS;
  localparam int LZW = $clog2(AW + 1);

  logic [M:0]            a_mant;
  logic [M:0]            b_mant;
  logic signed [TEW-1:0] a_te;
  logic signed [TEW-1:0] b_te;
  logic [FF-1:0]         prod;
  logic signed [TEW-1:0] mul_te;
  logic [FF-1:0]         mul_frac;
  logic                  b_sign_eff;
  logic                  a_is_big;
  logic                  big_sign;
  logic                  small_sign;
  logic signed [TEW-1:0] big_te;
  logic signed [TEW-1:0] small_te;
  logic [M:0]            big_mant;
  logic [M:0]            small_mant;
  logic [TEW-1:0]        exp_diff;
  logic [LZW-1:0]        shamt;
  logic [2*AW-1:0]       small_wide;
  logic                  align_sticky;
  logic [AW-1:0]         big_op;
  logic [AW-1:0]         small_op;
  logic [AW-1:0]         sum;
  logic [LZW-1:0]        lz;
  logic [AW-1:0]         norm;
  logic signed [TEW-1:0] add_te;
  logic [FF-1:0]         add_frac;

  assign a_mant = {1'b1, a_frac_i};  // Hidden one restored.
  assign b_mant = {1'b1, b_frac_i};
  assign a_te   = a_te_i;
  assign b_te   = b_te_i;

  // The product lies in [1, 4). Normalise by one place when it reaches 2.
  assign prod = a_mant * b_mant;
  always_comb begin
    if (prod[FF-1]) begin
      mul_te   = a_te + b_te + 1;
      mul_frac = {prod[FF-2:0], 1'b0};
    end else begin
      mul_te   = a_te + b_te;
      mul_frac = {prod[FF-3:0], 2'b00};
    end
  end

  // Subtraction is addition with the sign of b flipped.
  assign b_sign_eff = b_sign_i ^ (op_i == OP_SUB);
  assign a_is_big   = (a_te_i > b_te_i) || ((a_te_i == b_te_i) && (a_frac_i >= b_frac_i));

  assign big_sign   = a_is_big ? a_sign_i : b_sign_eff;
  assign small_sign = a_is_big ? b_sign_eff : a_sign_i;
  assign big_te     = a_is_big ? a_te : b_te;
  assign small_te   = a_is_big ? b_te : a_te;
  assign big_mant   = a_is_big ? a_mant : b_mant;
  assign small_mant = a_is_big ? b_mant : a_mant;

  assign exp_diff = big_te - small_te;
  assign shamt    = (exp_diff > AW) ? LZW'(AW) : exp_diff[LZW-1:0];

  // The lower half catches every bit that the alignment shifts out.
  assign small_wide   = {1'b0, small_mant, {(M+1){1'b0}}, 1'b0, {AW{1'b0}}} >> shamt;
  assign align_sticky = |small_wide[AW-1:0];
  assign small_op     = {small_wide[2*AW-1:AW+1], small_wide[AW] | align_sticky};
  assign big_op       = {1'b0, big_mant, {(M+1){1'b0}}, 1'b0};

  // A sticky LSB on the subtrahend acts as the borrow of the lost bits.
  assign sum = (big_sign ^ small_sign) ? big_op - small_op : big_op + small_op;

  always_comb begin
    logic found;
    lz    = '0;
    found = 1'b0;
    for (int i = AW - 1; i >= 0; i--) begin
      if (!found) begin
        if (sum[i]) begin
          found = 1'b1;
        end else begin
          lz = lz + 1'b1;
        end
      end
    end
  end

  assign norm     = sum << lz;
  assign add_frac = norm[AW-2:1];                             // Bits below the leading one.
  assign add_te   = big_te + 1 - $signed({1'b0, lz});  // Leading one at AW-2 means te is big_te.

  always_comb begin
    res_is_nar_o     = a_is_nar_i | b_is_nar_i;
    res_is_zero_o    = 1'b0;
    res_sign_o       = big_sign;
    res_te_o         = add_te;
    res_frac_full_o  = add_frac;
    frac_truncated_o = norm[0] | align_sticky;
    if (op_i == OP_MUL) begin
      res_is_zero_o    = a_is_zero_i | b_is_zero_i;
      res_sign_o       = a_sign_i ^ b_sign_i;
      res_te_o         = mul_te;
      res_frac_full_o  = mul_frac;
      frac_truncated_o = 1'b0;  // The product is exact.
    end else if (a_is_zero_i && b_is_zero_i) begin
      res_is_zero_o = 1'b1;
    end else if (a_is_zero_i) begin
      // The other operand passes through and re-encodes to itself.
      res_sign_o       = b_sign_eff;
      res_te_o         = b_te;
      res_frac_full_o  = {b_frac_i, {(FF-M){1'b0}}};
      frac_truncated_o = 1'b0;
    end else if (b_is_zero_i) begin
      res_sign_o       = a_sign_i;
      res_te_o         = a_te;
      res_frac_full_o  = {a_frac_i, {(FF-M){1'b0}}};
      frac_truncated_o = 1'b0;
    end else begin
      res_is_zero_o = (sum == '0);  // Exact cancellation.
    end
  end

endmodule

/* src/pack_fields.sv */
module pack_fields
  import posit_pkg::*;
  import ppu_ops_pkg::*;
#(
  parameter int N = 16,
  parameter int ES = 1,
  localparam int RB = regime_bits_f(N),
  localparam int TEW = te_bits_f(N, ES) + TE_GROW,
  localparam int M = mant_size_f(N, ES),
  localparam int FF = frac_full_size_f(N, ES)
) (
  input  logic [FF-1:0]         frac_full_i,
  input  logic signed [TEW-1:0] total_exp_i,
  input  logic                  frac_truncated_i,
  output logic signed [RB-1:0]  k_o,
  output logic [ES-1:0]         next_exp_o,
  output logic [M-1:0]          frac_o,
  output logic                  round_bit_o,
  output logic                  sticky_bit_o,
  output logic                  k_is_oob_o,
  output logic                  non_zero_frac_field_size_o
);

  localparam int KMAX = N - 2;

  logic signed [TEW-1:0] k_full;
  logic signed [TEW-1:0] k_clamped;
  logic [ES-1:0]         exp_bits;
  logic [ES+FF-1:0]      tail;
  logic [ES+FF-1:0]      tail_shifted;

  assign k_full   = total_exp_i >>> ES;  // Floor division by 2^ES.
  assign exp_bits = total_exp_i[ES-1:0];

  // At k = KMAX the regime already fills the word, so nothing larger exists.
  assign k_is_oob_o = (k_full >= KMAX) || (k_full < -KMAX);
  assign k_clamped  = (k_full > KMAX) ? TEW'(KMAX) :
                      (k_full < -KMAX) ? TEW'(-KMAX) : k_full;
  assign k_o        = k_clamped[RB-1:0];

  assign tail = {exp_bits, frac_full_i};

  always_comb begin
    int reg_len;
    int avail;
    int exp_size;
    int frac_size;
    reg_len  = (k_clamped >= 0) ? int'(k_clamped) + 2 : 1 - int'(k_clamped);
    avail    = N - 1 - reg_len;
    if (avail < 0) begin
      avail = 0;  // The terminator of the longest regime falls off the word.
    end
    exp_size  = (avail < ES) ? avail : ES;
    frac_size = avail - exp_size;

    next_exp_o                 = exp_bits & ~({ES{1'b1}} >> exp_size);
    frac_o                     = frac_full_i[FF-1 -: M] & ~({M{1'b1}} >> frac_size);
    non_zero_frac_field_size_o = (frac_size != 0);

    // The first bit that does not fit is the round bit, the rest is sticky.
    tail_shifted = tail << avail;
    round_bit_o  = tail_shifted[ES+FF-1];
    sticky_bit_o = (|tail_shifted[ES+FF-2:0]) | frac_truncated_i;
  end

endmodule

/* src/posit_encoder.sv */
module posit_encoder
  import posit_pkg::*;
#(
  parameter int N = 16,
  parameter int ES = 1,
  localparam int RB = regime_bits_f(N),
  localparam int M = mant_size_f(N, ES)
) (
  input  logic                 is_zero_i,
  input  logic                 is_nar_i,
  input  logic signed [RB-1:0] k_i,
  input  logic [ES-1:0]        exp_i,
  input  logic [M-1:0]         frac_i,
  output logic [N-1:0]         posit_o
);

  localparam int FW = N + ES + M;

  logic [N-1:0]  regime;
  logic [FW-1:0] assembled;

  always_comb begin
    int reg_len;
    if (k_i >= 0) begin
      regime  = {N{1'b1}} << (N - 1 - int'(k_i));  // k+1 ones, then the zero terminator.
      reg_len = int'(k_i) + 2;
    end else begin
      regime  = {1'b1, {(N-1){1'b0}}} >> (-int'(k_i));
      reg_len = 1 - int'(k_i);
    end
    // Exponent and fraction follow straight after the terminator.
    assembled = {regime, {(ES+M){1'b0}}} | ({exp_i, frac_i, {N{1'b0}}} >> reg_len);
  end

  always_comb begin
    if (is_nar_i) begin
      posit_o = {1'b1, {(N-1){1'b0}}};
    end else if (is_zero_i) begin
      posit_o = '0;
    end else begin
      posit_o = {1'b0, assembled[FW-1 -: N-1]};  // Truncated to the word.
    end
  end

endmodule

/* src/round_posit.sv */
module round_posit #(
  parameter int N = 16
) (
  input  logic [N-1:0] posit_i,
  input  logic         sign_i,
  input  logic         round_bit_i,
  input  logic         sticky_bit_i,
  input  logic         k_is_oob_i,
  input  logic         non_zero_frac_field_size_i,
  output logic [N-1:0] posit_o
);

  logic          special;
  logic          saturate;
  logic          round_up;
  logic [N-1:0]  rounded;

  // Zero and NaR are the only patterns with an empty body.
  assign special = ~|posit_i[N-2:0];

  // The regime has pushed every fraction bit out, hold at maxpos or minpos.
  assign saturate = k_is_oob_i & ~non_zero_frac_field_size_i;

  // Nearest, ties to even.
  assign round_up = round_bit_i & (sticky_bit_i | posit_i[0]) & ~saturate & ~special;
  assign rounded  = posit_i + N'(round_up);

  assign posit_o = (sign_i && !special) ? -rounded : rounded;  // Two's complement for negatives.

endmodule

/* src/fir_to_posit.sv */
module fir_to_posit
  import posit_pkg::*;
  import ppu_ops_pkg::*;
#(
  parameter int N = 16,
  parameter int ES = 1,
  localparam int RB = regime_bits_f(N),
  localparam int TEW = te_bits_f(N, ES) + TE_GROW,
  localparam int M = mant_size_f(N, ES),
  localparam int FF = frac_full_size_f(N, ES)
) (
  input  logic                  sign_i,
  input  logic signed [TEW-1:0] te_i,
  input  logic [FF-1:0]         frac_full_i,
  input  logic                  frac_truncated_i,
  input  logic                  is_zero_i,
  input  logic                  is_nar_i,
  output logic [N-1:0]          posit_o
);

  logic signed [RB-1:0] k;
  logic [ES-1:0]        next_exp;
  logic [M-1:0]         frac;
  logic                 round_bit;
  logic                 sticky_bit;
  logic                 k_is_oob;
  logic                 non_zero_frac_field_size;
  logic [N-1:0]         posit_encoded;

  pack_fields #(
    .N (N),
    .ES(ES)
  ) i_pack_fields (
    .frac_full_i               (frac_full_i),
    .total_exp_i               (te_i),
    .frac_truncated_i          (frac_truncated_i),
    .k_o                       (k),
    .next_exp_o                (next_exp),
    .frac_o                    (frac),
    .round_bit_o               (round_bit),
    .sticky_bit_o              (sticky_bit),
    .k_is_oob_o                (k_is_oob),
    .non_zero_frac_field_size_o(non_zero_frac_field_size)
  );

  // The encoder works on the magnitude, the sign comes last.
  posit_encoder #(
    .N (N),
    .ES(ES)
  ) i_posit_encoder (
    .is_zero_i(is_zero_i),
    .is_nar_i (is_nar_i),
    .k_i      (k),
    .exp_i    (next_exp),
    .frac_i   (frac),
    .posit_o  (posit_encoded)
  );

  round_posit #(
    .N(N)
  ) i_round_posit (
    .posit_i                   (posit_encoded),
    .sign_i                    (sign_i),
    .round_bit_i               (round_bit),
    .sticky_bit_i              (sticky_bit),
    .k_is_oob_i                (k_is_oob),
    .non_zero_frac_field_size_i(non_zero_frac_field_size),
    .posit_o                   (posit_o)
  );

endmodule

/* src/ppu_top.sv */
module ppu_top
  import posit_pkg::*;
  import ppu_ops_pkg::*;
#(
  parameter int N = 16,
  parameter int ES = 1,
  localparam int TE = te_bits_f(N, ES),
  localparam int TEW = TE + TE_GROW,
  localparam int M = mant_size_f(N, ES),
  localparam int FF = frac_full_size_f(N, ES)
) (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         valid_i,
  input  op_e          op_i,
  input  logic [N-1:0] a_i,
  input  logic [N-1:0] b_i,
  output logic         valid_o,
  output logic [N-1:0] result_o
);

  logic                  valid_q;
  op_e                   op_q;
  logic [N-1:0]          a_q;
  logic [N-1:0]          b_q;
  logic                  a_sign;
  logic signed [TE-1:0]  a_te;
  logic [M-1:0]          a_frac;
  logic                  a_is_zero;
  logic                  a_is_nar;
  logic                  b_sign;
  logic signed [TE-1:0]  b_te;
  logic [M-1:0]          b_frac;
  logic                  b_is_zero;
  logic                  b_is_nar;
  logic                  res_sign;
  logic signed [TEW-1:0] res_te;
  logic [FF-1:0]         res_frac_full;
  logic                  frac_truncated;
  logic                  res_is_zero;
  logic                  res_is_nar;
  logic [N-1:0]          result_d;

  // Stage 1 samples the operation.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      op_q <= op_i;
      a_q  <= a_i;
      b_q  <= b_i;
    end
  end

  posit_to_fir #(.N(N), .ES(ES)) i_decode_a (
    .posit_i  (a_q),
    .sign_o   (a_sign),
    .te_o     (a_te),
    .frac_o   (a_frac),
    .is_zero_o(a_is_zero),
    .is_nar_o (a_is_nar)
  );

  posit_to_fir #(.N(N), .ES(ES)) i_decode_b (
    .posit_i  (b_q),
    .sign_o   (b_sign),
    .te_o     (b_te),
    .frac_o   (b_frac),
    .is_zero_o(b_is_zero),
    .is_nar_o (b_is_nar)
  );

  posit_ops #(.N(N), .ES(ES)) i_posit_ops (
    .op_i            (op_q),
    .a_sign_i        (a_sign),
    .a_te_i          (a_te),
    .a_frac_i        (a_frac),
    .a_is_zero_i     (a_is_zero),
    .a_is_nar_i      (a_is_nar),
    .b_sign_i        (b_sign),
    .b_te_i          (b_te),
    .b_frac_i        (b_frac),
    .b_is_zero_i     (b_is_zero),
    .b_is_nar_i      (b_is_nar),
    .res_sign_o      (res_sign),
    .res_te_o        (res_te),
    .res_frac_full_o (res_frac_full),
    .frac_truncated_o(frac_truncated),
    .res_is_zero_o   (res_is_zero),
    .res_is_nar_o    (res_is_nar)
  );

  fir_to_posit #(.N(N), .ES(ES)) i_fir_to_posit (
    .sign_i          (res_sign),
    .te_i            (res_te),
    .frac_full_i     (res_frac_full),
    .frac_truncated_i(frac_truncated),
    .is_zero_i       (res_is_zero),
    .is_nar_i        (res_is_nar),
    .posit_o         (result_d)
  );

  // Stage 2 holds the result, which appears two edges after valid_i.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid_q;
      if (valid_q) begin
        result_o <= result_d;
      end
    end
  end

endmodule

/* tb/tb_ppu_top.sv */
module tb_ppu_top
  import ppu_ops_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = 16;
  localparam int ES = 1;
  localparam int MAX_OPS = 64;
  localparam int DRAIN_TIMEOUT = 100;  // Cycles allowed for the last results to come out.

  logic         clk_i;
  logic         arst_n_i;
  logic         valid_i;
  op_e          op_i;
  logic [N-1:0] a_i;
  logic [N-1:0] b_i;
  logic         valid_o;
  logic [N-1:0] result_o;

  // Four words per operation: opcode, a, b, expected result.
  logic [15:0] pattern_mem [0:4*MAX_OPS-1];
  int          num_ops;

  logic [N-1:0] exp_result_q[$];
  int           exp_cycle_q[$];
  int           exp_index_q[$];

  logic [31:0] rng_state;
  int          cycle_count;
  int          check_count;
  int          mismatch_count;
  int          timing_count;
  int          timeout_count;
  int          other_count;
  int          received_count;

  ppu_top #(
    .N (N),
    .ES(ES)
  ) i_ppu_top (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (valid_i),
    .op_i    (op_i),
    .a_i     (a_i),
    .b_i     (b_i),
    .valid_o (valid_o),
    .result_o(result_o)
  );

  // 32-bit xorshift generator for the idle gaps.
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  // Counted on the rising edge, read on the falling edge where it is stable.
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  // Outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk_i) begin
    logic [N-1:0] exp_result;
    int           exp_cycle;
    int           exp_index;
    if (valid_o === 1'b1) begin
      received_count++;
      assert (exp_result_q.size() > 0) else begin
        other_count++;
        $display("valid_o rose at cycle %0d with no operation in flight.", cycle_count);
      end
      if (exp_result_q.size() > 0) begin
        exp_result = exp_result_q.pop_front();
        exp_cycle  = exp_cycle_q.pop_front();
        exp_index  = exp_index_q.pop_front();
        check_count += 2;
        assert (cycle_count == exp_cycle) else begin
          timing_count++;
          $display("Result of operation %0d came at cycle %0d instead of cycle %0d.",
                   exp_index, cycle_count, exp_cycle);
        end
        assert (result_o === exp_result) else begin
          mismatch_count++;
          $display("mismatch result_o in operation %0d: expected %h, actual %h",
                   exp_index, exp_result, result_o);
        end
      end
    end
  end

  initial begin
    int gap;
    int wait_cycles;
    arst_n_i       = 1'b0;
    valid_i        = 1'b0;
    op_i           = OP_ADD;
    a_i            = '0;
    b_i            = '0;
    rng_state      = 32'd43657;
    cycle_count    = 0;
    check_count    = 0;
    mismatch_count = 0;
    timing_count   = 0;
    timeout_count  = 0;
    other_count    = 0;
    received_count = 0;

    for (int i = 0; i < 4 * MAX_OPS; i++) begin
      pattern_mem[i] = 'x;  // Unloaded rows stay unknown and mark the end.
    end
    $readmemh("tb/ppu_patterns.hex", pattern_mem);
    num_ops = 0;
    while (num_ops < MAX_OPS && !$isunknown(pattern_mem[4*num_ops])) begin
      num_ops++;
    end
    assert (num_ops > 0) else begin
      other_count++;
      $display("The pattern file holds no operations.");
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_count++;
    assert (valid_o === 1'b0 && result_o === '0) else begin
      other_count++;
      $display("Outputs are not cleared while reset is asserted.");
    end
    arst_n_i = 1'b1;

    for (int i = 0; i < num_ops; i++) begin
      rng_state = next_random(rng_state);
      gap       = int'(rng_state % 3);  // A third of the operations follow back to back.
      @(negedge clk_i);
      valid_i = 1'b1;
      op_i    = op_e'(pattern_mem[4*i][1:0]);
      a_i     = pattern_mem[4*i+1];
      b_i     = pattern_mem[4*i+2];
      exp_result_q.push_back(pattern_mem[4*i+3]);
      exp_cycle_q.push_back(cycle_count + 2);
      exp_index_q.push_back(i);
      repeat (gap) begin
        @(negedge clk_i);
        valid_i = 1'b0;
      end
    end
    @(negedge clk_i);
    valid_i = 1'b0;

    wait_cycles = 0;
    while (exp_result_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    if (exp_result_q.size() != 0) begin
      timeout_count++;
      $display("Timed out with %0d results still missing.", exp_result_q.size());
    end

    // A few idle cycles catch any extra valid_o.
    repeat (4) @(negedge clk_i);
    assert (received_count == num_ops) else begin
      other_count++;
      $display("Received %0d results for %0d operations.", received_count, num_ops);
    end

    $display("checks %0d, mismatches %0d, timing errors %0d, timeouts %0d, other errors %0d",
             check_count, mismatch_count, timing_count, timeout_count, other_count);
    if (mismatch_count + timing_count + timeout_count + other_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* tb/ppu_patterns.hex */
// Columns: opcode (0 add, 1 sub, 2 mul, 3 reserved as add), a, b, expected result.
// All values are posit16 with es 1 in hex.
2 4800 4800 5200
2 4800 5000 5800
2 b800 5000 a800
2 7000 7000 7c00
0 4000 4000 5000
0 4800 5000 5c00
0 5800 c000 5000
1 4000 4800 d000
1 4800 4800 0000
1 4000 0001 4000
1 4000 00c8 3fff
0 4000 00c0 4000
0 4001 00c0 4002
0 4000 00c8 4001
2 7fff 7fff 7fff
2 0001 0001 0001
2 7fff b000 8001
2 0001 d000 ffff
2 8000 4000 8000
0 4000 8000 8000
2 0000 5800 0000
2 0000 8000 8000
0 0000 b800 b800
1 0000 b000 5000
3 4000 4000 5000

/* filelist.f */
src/posit_pkg.sv
src/ppu_ops_pkg.sv
src/posit_to_fir.sv
src/posit_ops.sv
src/pack_fields.sv
src/posit_encoder.sv
src/round_posit.sv
src/fir_to_posit.sv
src/ppu_top.sv
tb/tb_ppu_top.sv
